/* rtl/dcache_pkg.sv */
package dcache_pkg;

  localparam int addr_w         = 32;
  localparam int line_w         = 128;
  localparam int index_w        = 4;
  localparam int offset_w       = 4;
  localparam int tag_w          = addr_w - index_w - offset_w;
  localparam int num_lines      = 1 << index_w;
  localparam int cpu_data_w     = 64;
  localparam int axil_data_w    = 32;
  localparam int beats_per_line = line_w / axil_data_w;
  localparam int beat_w         = 2;                          // enough for beats_per_line

  typedef enum logic [1:0] {
    sz_byte   = 2'b00,
    sz_half   = 2'b01,
    sz_word   = 2'b10,
    sz_double = 2'b11
  } access_size_e;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_writeback,
    st_refill,
    st_fill_wait,
    st_respond
  } ctrl_state_e;

  // clears the low offset bits so the access sits on its natural boundary
  function automatic logic [offset_w-1:0] align_offset(input logic [offset_w-1:0] offset,
                                                       input access_size_e size);
    logic [offset_w-1:0] low_bits;
    low_bits = (offset_w'(1) << size) - offset_w'(1);
    return offset & ~low_bits;
  endfunction

  function automatic logic [cpu_data_w-1:0] size_mask(input access_size_e size);
    case (size)
      sz_byte: return cpu_data_w'(8'hff);
      sz_half: return cpu_data_w'(16'hffff);
      sz_word: return cpu_data_w'(32'hffff_ffff);
      default: return '1;                                     // full double
    endcase
  endfunction

endpackage

/* rtl/data_array.sv */
module data_array (
  input  logic                                clk,
  input  logic                                wren,
  input  logic                                fill,        // whole-line write from refill
  input  logic [dcache_pkg::index_w-1:0]      index,
  input  logic [dcache_pkg::offset_w-1:0]     offset,
  input  dcache_pkg::access_size_e            size,
  input  logic [dcache_pkg::cpu_data_w-1:0]   store_data,
  input  logic [dcache_pkg::line_w-1:0]       fill_line,
  output logic [dcache_pkg::line_w-1:0]       line_out
);

  import dcache_pkg::*;

  logic [line_w-1:0]   lines [0:num_lines-1];
  logic [offset_w-1:0] lane_off;
  logic [6:0]          lane_shift;                           // bit position of the lane
  logic [line_w-1:0]   lane_mask;
  logic [line_w-1:0]   lane_data;

  assign lane_off   = align_offset(offset, size);
  assign lane_shift = {lane_off, 3'b000};

  // only the low 1/2/4/8 bytes of store_data take part
  assign lane_mask = line_w'(size_mask(size)) << lane_shift;
  assign lane_data = line_w'(store_data) << lane_shift;

  always_ff @(negedge clk) begin
    if (wren) begin
      if (fill) begin
        lines[index] <= fill_line;                           // refill replaces the line
      end else begin
        lines[index] <= (lines[index] & ~lane_mask) | (lane_data & lane_mask);
      end
    end
  end

  assign line_out = lines[index];                            // combinational read

endmodule

/* rtl/tag_array.sv */
module tag_array (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dcache_pkg::index_w-1:0]  index,
  input  logic [dcache_pkg::tag_w-1:0]    tag,
  input  logic                            update,        // install clean valid entry
  input  logic                            set_dirty,
  output logic                            hit,
  output logic                            victim_dirty,
  output logic [dcache_pkg::tag_w-1:0]    victim_tag
);

  import dcache_pkg::*;

  logic [num_lines-1:0] valid;
  logic [num_lines-1:0] dirty;
  logic [tag_w-1:0]     tags [0:num_lines-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else if (update) begin
      valid[index] <= 1'b1;
      dirty[index] <= 1'b0;
    end else if (set_dirty) begin
      dirty[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (update) begin
      tags[index] <= tag;
    end
  end

  assign victim_tag   = tags[index];
  assign hit          = valid[index] && (tags[index] == tag);
  assign victim_dirty = valid[index] && dirty[index];       // a stale dirty bit never counts

endmodule

/* rtl/cache_ctrl.sv */
module cache_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  // cpu request / response
  input  logic                                req_valid,
  input  logic                                req_write,
  input  dcache_pkg::access_size_e            req_size,
  input  logic [dcache_pkg::addr_w-1:0]       req_addr,
  input  logic [dcache_pkg::cpu_data_w-1:0]   req_wdata,
  output logic                                req_ready,
  output logic                                resp_valid,
  output logic [dcache_pkg::cpu_data_w-1:0]   resp_rdata,
  // tag array
  input  logic                                hit,
  input  logic                                victim_dirty,
  input  logic [dcache_pkg::tag_w-1:0]        victim_tag,
  output logic                                update,
  output logic                                set_dirty,
  output logic [dcache_pkg::tag_w-1:0]        new_tag,
  // data array
  input  logic [dcache_pkg::line_w-1:0]       line_out,
  output logic                                wren,
  output logic                                fill,
  output dcache_pkg::access_size_e            size,
  output logic [dcache_pkg::offset_w-1:0]     offset,
  output logic [dcache_pkg::index_w-1:0]      index,
  output logic [dcache_pkg::cpu_data_w-1:0]   store_data,
  // line master
  input  logic [dcache_pkg::line_w-1:0]       rline,
  input  logic                                done,
  output logic                                start,
  output logic                                write,
  output logic [dcache_pkg::addr_w-1:0]       line_addr,
  output logic [dcache_pkg::line_w-1:0]       wline
);

  import dcache_pkg::*;

  ctrl_state_e          state;
  ctrl_state_e          state_nxt;
  logic                 write_q;
  access_size_e         size_q;
  logic [addr_w-1:0]    addr_q;
  logic [cpu_data_w-1:0] wdata_q;
  logic [line_w-1:0]    load_line;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // accepted request is held until its response
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      write_q <= req_write;
      size_q  <= req_size;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  assign index      = addr_q[offset_w +: index_w];
  assign offset     = addr_q[offset_w-1:0];
  assign new_tag    = addr_q[addr_w-1 -: tag_w];
  assign size       = size_q;
  assign store_data = wdata_q;
  assign wline      = line_out;                              // victim line, latched by the master

  assign req_ready  = (state == st_idle);
  assign resp_valid = (state == st_respond);

  // load value: shift the addressed lane down, keep only its bytes
  assign load_line  = line_out >> {align_offset(offset, size_q), 3'b000};
  assign resp_rdata = load_line[cpu_data_w-1:0] & size_mask(size_q);

  always_comb begin
    state_nxt = state;
    wren      = 1'b0;
    fill      = 1'b0;
    update    = 1'b0;
    set_dirty = 1'b0;
    start     = 1'b0;
    write     = 1'b0;
    line_addr = {new_tag, index, {offset_w{1'b0}}};          // line of the request

    case (state)
      st_idle: begin
        if (req_valid) state_nxt = st_lookup;
      end
      st_lookup: begin
        if (hit) begin
          state_nxt = st_respond;
        end else begin
          start = 1'b1;
          if (victim_dirty) begin
            write     = 1'b1;
            line_addr = {victim_tag, index, {offset_w{1'b0}}};
            state_nxt = st_writeback;
          end else begin
            state_nxt = st_refill;
          end
        end
      end
      st_writeback: begin
        if (done) begin
          start     = 1'b1;                                  // victim is out, fetch new line
          state_nxt = st_refill;
        end
      end
      st_refill: begin
        if (done) state_nxt = st_fill_wait;
      end
      st_fill_wait: begin
        wren      = 1'b1;
        fill      = 1'b1;
        update    = 1'b1;
        state_nxt = st_respond;
      end
      st_respond: begin
        wren      = write_q;                                 // lane store at the falling edge
        set_dirty = write_q;
        state_nxt = st_idle;
      end
      default: state_nxt = st_idle;
    endcase
  end

endmodule

/* rtl/axil_line_master.sv */
module axil_line_master (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start,
  input  logic                                   write,
  input  logic [dcache_pkg::addr_w-1:0]          line_addr,
  input  logic [dcache_pkg::line_w-1:0]          wline,
  output logic                                   done,
  output logic [dcache_pkg::line_w-1:0]          rline,
  // AXI4-Lite master
  output logic                                   m_axil_awvalid,
  input  logic                                   m_axil_awready,
  output logic [dcache_pkg::addr_w-1:0]          m_axil_awaddr,
  output logic                                   m_axil_wvalid,
  input  logic                                   m_axil_wready,
  output logic [dcache_pkg::axil_data_w-1:0]     m_axil_wdata,
  output logic [dcache_pkg::axil_data_w/8-1:0]   m_axil_wstrb,
  input  logic                                   m_axil_bvalid,
  output logic                                   m_axil_bready,
  output logic                                   m_axil_arvalid,
  input  logic                                   m_axil_arready,
  output logic [dcache_pkg::addr_w-1:0]          m_axil_araddr,
  input  logic                                   m_axil_rvalid,
  output logic                                   m_axil_rready,
  input  logic [dcache_pkg::axil_data_w-1:0]     m_axil_rdata
);

  import dcache_pkg::*;

  typedef enum logic [1:0] {ph_idle, ph_addr, ph_resp} phase_e;

  phase_e             phase;
  logic [beat_w-1:0]  beat;
  logic               aw_sent;                               // AW taken for this beat
  logic               w_sent;                                // W taken for this beat
  logic               write_q;
  logic [addr_w-1:0]  base_q;
  logic [line_w-1:0]  wline_q;
  logic               last_beat;
  logic [addr_w-1:0]  beat_addr;

  assign last_beat = (beat == beat_w'(beats_per_line - 1));
  assign beat_addr = {base_q[addr_w-1:offset_w], beat, {(offset_w - beat_w){1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      phase   <= ph_idle;
      beat    <= '0;
      aw_sent <= 1'b0;
      w_sent  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (phase)
        ph_idle: begin
          if (start) begin
            phase   <= ph_addr;
            beat    <= '0;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
          end
        end
        ph_addr: begin
          if (write_q) begin
            if (m_axil_awvalid && m_axil_awready) aw_sent <= 1'b1;
            if (m_axil_wvalid && m_axil_wready) w_sent <= 1'b1;
            if ((aw_sent || m_axil_awready) && (w_sent || m_axil_wready)) begin
              phase <= ph_resp;                              // both halves of the write are in
            end
          end else if (m_axil_arready) begin
            phase <= ph_resp;
          end
        end
        ph_resp: begin
          if (write_q ? m_axil_bvalid : m_axil_rvalid) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
            beat    <= beat + 1'b1;
            if (last_beat) begin
              phase <= ph_idle;
              done  <= 1'b1;
            end else begin
              phase <= ph_addr;
            end
          end
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == ph_idle && start) begin
      write_q <= write;
      base_q  <= line_addr;
      wline_q <= wline;
    end
    if (phase == ph_resp && !write_q && m_axil_rvalid) begin
      rline[beat*axil_data_w +: axil_data_w] <= m_axil_rdata;  // word k fills bytes 4k..4k+3
    end
  end

  assign m_axil_awvalid = (phase == ph_addr) && write_q && !aw_sent;
  assign m_axil_wvalid  = (phase == ph_addr) && write_q && !w_sent;
  assign m_axil_arvalid = (phase == ph_addr) && !write_q;
  assign m_axil_bready  = (phase == ph_resp) && write_q;
  assign m_axil_rready  = (phase == ph_resp) && !write_q;

  assign m_axil_awaddr  = beat_addr;
  assign m_axil_araddr  = beat_addr;
  assign m_axil_wdata   = wline_q[beat*axil_data_w +: axil_data_w];
  assign m_axil_wstrb   = '1;

endmodule

/* rtl/dcache_top.sv */
module dcache_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   req_valid,
  input  logic                                   req_write,
  input  dcache_pkg::access_size_e               req_size,
  input  logic [dcache_pkg::addr_w-1:0]          req_addr,
  input  logic [dcache_pkg::cpu_data_w-1:0]      req_wdata,
  output logic                                   req_ready,
  output logic                                   resp_valid,
  output logic [dcache_pkg::cpu_data_w-1:0]      resp_rdata,
  output logic                                   m_axil_awvalid,
  input  logic                                   m_axil_awready,
  output logic [dcache_pkg::addr_w-1:0]          m_axil_awaddr,
  output logic                                   m_axil_wvalid,
  input  logic                                   m_axil_wready,
  output logic [dcache_pkg::axil_data_w-1:0]     m_axil_wdata,
  output logic [dcache_pkg::axil_data_w/8-1:0]   m_axil_wstrb,
  input  logic                                   m_axil_bvalid,
  output logic                                   m_axil_bready,
  output logic                                   m_axil_arvalid,
  input  logic                                   m_axil_arready,
  output logic [dcache_pkg::addr_w-1:0]          m_axil_araddr,
  input  logic                                   m_axil_rvalid,
  output logic                                   m_axil_rready,
  input  logic [dcache_pkg::axil_data_w-1:0]     m_axil_rdata
);

  import dcache_pkg::*;

  logic                  hit, victim_dirty, update, set_dirty;
  logic [tag_w-1:0]      victim_tag, new_tag;
  logic                  wren, fill;
  access_size_e          size;
  logic [offset_w-1:0]   offset;
  logic [index_w-1:0]    index;
  logic [cpu_data_w-1:0] store_data;
  logic [line_w-1:0]     line_out, rline, wline;
  logic                  start, write, done;
  logic [addr_w-1:0]     line_addr;

  cache_ctrl i_ctrl (
    .clk, .rst,
    .req_valid, .req_write, .req_size, .req_addr, .req_wdata,
    .req_ready, .resp_valid, .resp_rdata,
    .hit, .victim_dirty, .victim_tag, .update, .set_dirty, .new_tag,
    .line_out, .wren, .fill, .size, .offset, .index, .store_data,
    .rline, .done, .start, .write, .line_addr, .wline
  );

  tag_array i_tags (
    .clk, .rst, .index, .tag(new_tag), .update, .set_dirty,
    .hit, .victim_dirty, .victim_tag
  );

  data_array i_data (
    .clk, .wren, .fill, .index, .offset, .size, .store_data,
    .fill_line(rline), .line_out
  );

  axil_line_master i_axil (
    .clk, .rst, .start, .write, .line_addr, .wline, .done, .rline,
    .m_axil_awvalid, .m_axil_awready, .m_axil_awaddr,
    .m_axil_wvalid, .m_axil_wready, .m_axil_wdata, .m_axil_wstrb,
    .m_axil_bvalid, .m_axil_bready,
    .m_axil_arvalid, .m_axil_arready, .m_axil_araddr,
    .m_axil_rvalid, .m_axil_rready, .m_axil_rdata
  );

endmodule

/* verif/tb_clk.sv */
module tb_clk (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk;                                     // 40 unit period

endmodule

/* verif/axil_mem_model.sv */
module axil_mem_model (
  input  logic        clk, rst,
  input  logic        stall,                                 // holds every ready low this cycle
  input  logic        m_axil_awvalid, m_axil_wvalid, m_axil_bready,
  input  logic        m_axil_arvalid, m_axil_rready,
  input  logic [31:0] m_axil_awaddr, m_axil_wdata, m_axil_araddr,
  output logic        m_axil_awready, m_axil_wready, m_axil_arready,
  output logic        m_axil_bvalid, m_axil_rvalid,
  output logic [31:0] m_axil_rdata
);

  logic [31:0] mem [logic [31:0]];                           // only written words are kept
  logic        aw_got, w_got;
  logic [31:0] aw_addr_q, w_data_q;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return addr ^ 32'h5a5a_0000;                             // untouched word, address pattern
  endfunction

  assign m_axil_awready = !stall && !aw_got && !m_axil_bvalid;
  assign m_axil_wready  = !stall && !w_got && !m_axil_bvalid;
  assign m_axil_arready = !stall && !m_axil_rvalid;

  always @(posedge clk) begin
    if (rst) begin
      aw_got        <= 1'b0;
      w_got         <= 1'b0;
      m_axil_bvalid <= 1'b0;
      m_axil_rvalid <= 1'b0;
    end else begin
      if (m_axil_awvalid && m_axil_awready) begin
        aw_got    <= 1'b1;
        aw_addr_q <= m_axil_awaddr;
      end
      if (m_axil_wvalid && m_axil_wready) begin
        w_got    <= 1'b1;
        w_data_q <= m_axil_wdata;
      end
      // both halves in, commit the word and answer on B
      if (aw_got && w_got) begin
        mem[aw_addr_q] = w_data_q;
        aw_got        <= 1'b0;
        w_got         <= 1'b0;
        m_axil_bvalid <= 1'b1;
      end else if (m_axil_bready) begin
        m_axil_bvalid <= 1'b0;
      end
      if (m_axil_arvalid && m_axil_arready) begin
        m_axil_rvalid <= 1'b1;
        m_axil_rdata  <= read_word(m_axil_araddr);
      end else if (m_axil_rready) begin
        m_axil_rvalid <= 1'b0;
      end
    end
  end

endmodule

/* verif/dcache_checker.sv */
module dcache_checker (
  input  logic                     clk, rst,
  input  logic                     req_valid, req_ready, req_write, resp_valid,
  input  dcache_pkg::access_size_e req_size,
  input  logic [31:0]              req_addr,
  input  logic [63:0]              req_wdata, resp_rdata,
  input  logic                     m_axil_awvalid, m_axil_awready, m_axil_wvalid,
  input  logic                     m_axil_wready, m_axil_arvalid, m_axil_arready,
  input  logic [31:0]              m_axil_awaddr, m_axil_wdata, m_axil_araddr,
  input  logic [3:0]               m_axil_wstrb,
  output int                       data_errs, proto_errs, timing_errs, resp_count
);

  import dcache_pkg::*;

  logic [7:0]                 shadow [logic [31:0]];         // bytes from accepted stores
  logic [num_lines-1:0]       res_valid;
  logic [addr_w-offset_w-1:0] res_line [0:num_lines-1];      // line the cache holds per index
  logic                       pending, exp_write, exp_hit;
  logic [31:0]                exp_addr;
  logic [63:0]                exp_data;
  int                         age;                           // edges since acceptance
  logic                       aw_wait, w_wait, ar_wait;
  logic [31:0]                aw_held, w_held, ar_held;

  function automatic logic [7:0] byte_at(input logic [31:0] a);
    logic [31:0] word;
    word = {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    if (shadow.exists(a)) return shadow[a];
    return word[8*a[1:0] +: 8];
  endfunction

  // aligned bytes of the access, zero-extended to 64 bits
  function automatic logic [63:0] expected_load(input logic [31:0] addr, input access_size_e size);
    int          nbytes;
    logic [31:0] base;
    logic [63:0] val;
    nbytes = 1 << int'(size);
    base   = addr & ~(32'(nbytes) - 32'd1);
    val    = '0;
    for (int i = 0; i < nbytes; i++) begin
      val[8*i +: 8] = byte_at(base + 32'(i));
    end
    return val;
  endfunction

  task automatic store_bytes(input logic [31:0] addr, input access_size_e size,
                             input logic [63:0] data);
    int          nbytes;
    logic [31:0] base;
    nbytes = 1 << int'(size);
    base   = addr & ~(32'(nbytes) - 32'd1);
    for (int i = 0; i < nbytes; i++) begin
      shadow[base + 32'(i)] = data[8*i +: 8];
    end
  endtask

  // a payload seen waiting last cycle must still be offered unchanged
  task automatic check_stable(input string name, input logic waiting, input logic valid,
                              input logic [31:0] held, input logic [31:0] now);
    if (waiting && !valid) begin
      $display("%0t: valid for %s dropped before its ready was seen", $time, name);
      proto_errs++;
    end else if (waiting && now !== held) begin
      $display("ERR %0t %s got %h expected %h", $time, name, now, held);
      proto_errs++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pending     = 1'b0;
      age         = 0;
      res_valid   = '0;
      aw_wait     = 1'b0;
      w_wait      = 1'b0;
      ar_wait     = 1'b0;
      data_errs   = 0;
      proto_errs  = 0;
      timing_errs = 0;
      resp_count  = 0;
    end else begin
      check_stable("m_axil_awaddr", aw_wait, m_axil_awvalid, aw_held, m_axil_awaddr);
      check_stable("m_axil_wdata", w_wait, m_axil_wvalid, w_held, m_axil_wdata);
      check_stable("m_axil_araddr", ar_wait, m_axil_arvalid, ar_held, m_axil_araddr);
      if (m_axil_wvalid && m_axil_wstrb !== 4'hf) begin
        $display("ERR %0t m_axil_wstrb got %h expected %h", $time, m_axil_wstrb, 4'hf);
        proto_errs++;
      end
      aw_wait = m_axil_awvalid && !m_axil_awready;
      w_wait  = m_axil_wvalid && !m_axil_wready;
      ar_wait = m_axil_arvalid && !m_axil_arready;
      aw_held = m_axil_awaddr;
      w_held  = m_axil_wdata;
      ar_held = m_axil_araddr;
      if (pending) age = age + 1;
      if (resp_valid) begin
        if (!pending) begin
          $display("%0t: response seen with no request outstanding", $time);
          proto_errs++;
        end else begin
          if (!exp_write && resp_rdata !== exp_data) begin
            $display("ERR %0t resp_rdata got %h expected %h", $time, resp_rdata, exp_data);
            data_errs++;
          end
          if (exp_hit && age != 2) begin
            $display("ERR %0t resp_valid latency got %0d expected 2", $time, age);
            timing_errs++;
          end
          res_valid[exp_addr[offset_w +: index_w]] = 1'b1;  // write-allocate, line now held
          res_line[exp_addr[offset_w +: index_w]]  = exp_addr[addr_w-1:offset_w];
          pending = 1'b0;
          resp_count++;
        end
      end
      if (req_valid && req_ready) begin
        if (pending) begin
          $display("%0t: request accepted while another was outstanding", $time);
          proto_errs++;
        end
        pending   = 1'b1;
        age       = 0;
        exp_write = req_write;
        exp_addr  = req_addr;
        exp_hit   = res_valid[req_addr[offset_w +: index_w]] &&
                    (res_line[req_addr[offset_w +: index_w]] == req_addr[addr_w-1:offset_w]);
        if (req_write) begin
          store_bytes(req_addr, req_size, req_wdata);
        end else begin
          exp_data = expected_load(req_addr, req_size);
        end
      end
    end
  end

endmodule

/* verif/tb_top.sv */
module tb_top;

  import dcache_pkg::*;

  localparam int          num_reqs       = 300;
  localparam int          timeout_cycles = num_reqs * 60 + 200;
  localparam logic [31:0] window_base    = 32'h0000_2000;   // 1 KiB, four lines per index
  localparam logic [31:0] lfsr_seed      = 32'd45;

  logic                     clk, rst, stall;
  logic                     req_valid, req_write, req_ready, resp_valid;
  access_size_e             req_size;
  logic [addr_w-1:0]        req_addr;
  logic [cpu_data_w-1:0]    req_wdata, resp_rdata;
  logic                     m_axil_awvalid, m_axil_awready, m_axil_wvalid, m_axil_wready;
  logic                     m_axil_bvalid, m_axil_bready, m_axil_arvalid, m_axil_arready;
  logic                     m_axil_rvalid, m_axil_rready;
  logic [addr_w-1:0]        m_axil_awaddr, m_axil_araddr;
  logic [axil_data_w-1:0]   m_axil_wdata, m_axil_rdata;
  logic [axil_data_w/8-1:0] m_axil_wstrb;
  int                       data_errs, proto_errs, timing_errs, resp_count;
  int                       sent;
  int                       cycle_cnt = 0;
  logic [31:0]              lfsr;
  logic [63:0]              bits;

  tb_clk         i_clk (.clk);
  dcache_top     i_dut (.*);
  axil_mem_model i_mem (.*);
  dcache_checker i_check (.*);

  // galois form of x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[62:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic issue_request();
    take_bits(1, bits);
    req_write <= bits[0];
    take_bits(2, bits);
    req_size  <= access_size_e'(bits[1:0]);
    take_bits(10, bits);
    req_addr  <= window_base + 32'(bits[9:0]);
    take_bits(64, bits);
    req_wdata <= bits;
    req_valid <= 1'b1;
  endtask

  initial begin
    lfsr = lfsr_seed;
    sent = 0;
    rst       <= 1'b1;
    stall     <= 1'b0;
    req_valid <= 1'b0;
    req_write <= 1'b0;
    req_size  <= sz_byte;
    req_addr  <= '0;
    req_wdata <= '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    while (resp_count < num_reqs) begin
      @(posedge clk);
      take_bits(2, bits);
      stall <= &bits[1:0];                                   // about one cycle in four
      if (req_valid && req_ready) begin
        sent++;
        req_valid <= 1'b0;
      end
      if (sent < num_reqs && (!req_valid || req_ready)) issue_request();
    end
    repeat (4) @(posedge clk);                               // room for a stray extra response
    $display("errors: data %0d, protocol %0d, latency %0d", data_errs, proto_errs, timing_errs);
    if (data_errs + proto_errs + timing_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("timeout after %0d cycles, only %0d of %0d requests answered",
               cycle_cnt, resp_count, num_reqs);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* tb.f */
rtl/dcache_pkg.sv
rtl/data_array.sv
rtl/tag_array.sv
rtl/cache_ctrl.sv
rtl/axil_line_master.sv
rtl/dcache_top.sv
verif/tb_clk.sv
verif/axil_mem_model.sv
verif/dcache_checker.sv
verif/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
